//--- sources.f
hw/sdram_pkg.sv
hw/host_port.sv
hw/refresh_timer.sv
hw/sdram_sequencer.sv
hw/sdram_cmd_encoder.sv
hw/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/tb_sdram_ctrl.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
        --top-module tb_sdram_ctrl -f sources.f -o tb_sdram_ctrl; then
    echo "Verilator build failed"
    exit 1
fi
if ! ./obj_dir/tb_sdram_ctrl; then
    echo "Simulation failed"
    exit 1
fi
exit 0

//--- dv/tb_sdram_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sdram_ctrl
    import sdram_pkg::*;
();

    localparam int CAS_LATENCY      = 2;
    localparam int REFRESH_INTERVAL = 200;
    localparam int INIT_DELAY       = 20;
    localparam int RESET_CYCLES     = 8;
    localparam int ACK_TIMEOUT      = 100;
    localparam int INIT_TIMEOUT     = INIT_DELAY + 200;
    localparam int REFRESH_LIMIT    = REFRESH_INTERVAL + 20;
    localparam int RANDOM_OPS       = 200;

    // Burst length 1, sequential, CAS latency in 6:4, single write burst in bit 9
    localparam logic [ROW_WIDTH-1:0] MODE_WORD = ROW_WIDTH'((1 << 9) | (CAS_LATENCY << 4));
    localparam sdram_cmd_e INIT_ORDER [4] = '{cmd_precharge_all, cmd_auto_refresh,
                                              cmd_auto_refresh, cmd_load_mode};

    logic                  clk;
    logic                  rst;
    logic                  req;
    host_req_t             req_data;
    logic [DATA_WIDTH-1:0] dq_in;
    logic                  ack;
    logic [DATA_WIDTH-1:0] rdata;
    sdram_pins_t           pins;
    logic [DATA_WIDTH-1:0] dq_out;
    logic                  dq_oe;

    integer                seed;
    logic [DATA_WIDTH-1:0] shadow [logic [ADDR_WIDTH-1:0]];
    int                    init_idx = 0;
    logic                  init_seen = 1'b0;
    int                    cycle = 0;
    int                    last_ref = 0;
    int                    ref_count = 0;
    host_op_e              exp_op = op_read;
    logic [ADDR_WIDTH-1:0] exp_addr = '0;
    logic [DATA_WIDTH-1:0] exp_wdata = '0;
    logic                  ack_q = 1'b0;
    logic                  req_q = 1'b0;
    logic [DATA_WIDTH-1:0] rdata_q = '0;

    sdram_ctrl_top #(
        .CAS_LATENCY      (CAS_LATENCY),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .INIT_DELAY       (INIT_DELAY)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .dq_in    (dq_in),
        .ack      (ack),
        .rdata    (rdata),
        .pins     (pins),
        .dq_out   (dq_out),
        .dq_oe    (dq_oe)
    );

    sdram_model #(
        .CAS_LATENCY (CAS_LATENCY)
    ) u_model (
        .clk    (clk),
        .pins   (pins),
        .dq_out (dq_out),
        .dq_oe  (dq_oe),
        .dq_in  (dq_in)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_cmd(input sdram_cmd_e got, input sdram_cmd_e exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at time %0t: %s is %s, expected %s",
                                $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_pins_addr(input logic [BANK_WIDTH-1:0] got_ba,
                                   input logic [BANK_WIDTH-1:0] exp_ba,
                                   input logic [ROW_WIDTH-1:0] got_a,
                                   input logic [ROW_WIDTH-1:0] exp_a, input string what);
        if (got_ba !== exp_ba || got_a !== exp_a) begin
            abort_run($sformatf("Fail at time %0t: %s is ba %h a %h, expected ba %h a %h",
                                $time, what, got_ba, got_a, exp_ba, exp_a));
        end
    endtask

    // Standard SDRAM command truth table on cs_n, ras_n, cas_n, we_n
    function automatic sdram_cmd_e decode_pins(input sdram_pins_t p);
        if (p.cs_n) begin
            return cmd_nop;
        end
        case ({p.ras_n, p.cas_n, p.we_n})
            3'b011:  return cmd_active;
            3'b101:  return cmd_read;
            3'b100:  return cmd_write;
            3'b010:  return cmd_precharge_all;
            3'b001:  return cmd_auto_refresh;
            3'b000:  return cmd_load_mode;
            default: return cmd_nop;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] reference_read(input logic [ADDR_WIDTH-1:0] addr);
        return shadow.exists(addr) ? shadow[addr] : '0;
    endfunction

    // 4 banks x 4 rows x 8 columns, touching the high row and column bits
    function automatic logic [ADDR_WIDTH-1:0] random_addr();
        logic [BANK_WIDTH-1:0] bank;
        logic [ROW_WIDTH-1:0]  row;
        logic [COL_WIDTH-1:0]  col;
        bank = BANK_WIDTH'($random(seed));
        row  = {2'($random(seed)), 11'h2a5};
        col  = {3'($random(seed)), 7'h13};
        return {bank, row, col};
    endfunction

    task automatic raise_request(input host_op_e op_kind, input logic [ADDR_WIDTH-1:0] address,
                                 input logic [DATA_WIDTH-1:0] word);
        @(posedge clk);
        req       <= 1'b1;
        req_data  <= '{op: op_kind, addr: address, wdata: word};
        exp_op    <= op_kind;
        exp_addr  <= address;
        exp_wdata <= word;
    endtask

    task automatic finish_request(input host_op_e op_kind, input logic [ADDR_WIDTH-1:0] address,
                                  input logic [DATA_WIDTH-1:0] word);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("the controller never raised ack for a request");
            end
        end while (!ack);
        if (op_kind == op_read) begin
            check_word(rdata, reference_read(address), "read data");
        end else begin
            shadow[address] = word;
        end
        req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                abort_run("the controller never dropped ack after req fell");
            end
        end while (ack);
    endtask

    task automatic host_access(input host_op_e op_kind, input logic [ADDR_WIDTH-1:0] address,
                               input logic [DATA_WIDTH-1:0] word);
        raise_request(op_kind, address, word);
        finish_request(op_kind, address, word);
    endtask

    // Pin monitor
    always @(posedge clk) begin
        sdram_cmd_e c;
        c = decode_pins(pins);
        cycle <= cycle + 1;
        if (!rst && dq_oe !== (c == cmd_write)) begin
            abort_run($sformatf("Fail at time %0t: dq_oe is %b while the pins carry %s",
                                $time, dq_oe, c.name()));
        end
        if (!rst && !init_seen) begin
            if (ack) begin
                abort_run("ack went high before initialization finished");
            end
            if (c != cmd_nop) begin
                check_cmd(c, INIT_ORDER[init_idx], "init command");
                init_idx <= init_idx + 1;
                if (c == cmd_load_mode) begin
                    check_pins_addr(pins.ba, '0, pins.a, MODE_WORD, "mode register load");
                    init_seen <= 1'b1;
                    last_ref  <= cycle;
                end
            end
        end else if (!rst) begin
            if (cycle - last_ref > REFRESH_LIMIT) begin
                abort_run($sformatf("Fail at time %0t: no auto_refresh for %0d cycles",
                                    $time, cycle - last_ref));
            end
            case (c)
                cmd_auto_refresh: begin
                    last_ref  <= cycle;
                    ref_count <= ref_count + 1;
                end
                cmd_active: begin
                    check_pins_addr(pins.ba, exp_addr[ADDR_WIDTH-1 -: BANK_WIDTH], pins.a,
                                    exp_addr[COL_WIDTH +: ROW_WIDTH], "ACTIVE");
                end
                cmd_read, cmd_write: begin
                    check_cmd(c, (exp_op == op_write) ? cmd_write : cmd_read, "access command");
                    // Column with A10 set for auto-precharge
                    check_pins_addr(pins.ba, exp_addr[ADDR_WIDTH-1 -: BANK_WIDTH], pins.a,
                                    {(ROW_WIDTH-COL_WIDTH-1)'(0), 1'b1, exp_addr[COL_WIDTH-1:0]},
                                    "READ/WRITE");
                    if (c == cmd_write) begin
                        check_word(dq_out, exp_wdata, "write data on dq_out");
                    end
                end
                cmd_nop, cmd_precharge_all: ;
                default: abort_run($sformatf("unexpected %s command after init", c.name()));
            endcase
        end
    end

    // Four-phase handshake rules
    always @(posedge clk) begin
        if (!rst) begin
            if (ack && !ack_q && !req) begin
                abort_run("ack rose while req was low");
            end
            if (ack_q && req_q && !ack) begin
                abort_run("ack fell while req was still high");
            end
            if (ack_q && !req_q && ack) begin
                abort_run("ack stayed high after req fell");
            end
            if (ack_q && ack) begin
                check_word(rdata, rdata_q, "rdata during ack");
            end
        end
        ack_q   <= ack;
        req_q   <= req;
        rdata_q <= rdata;
    end

    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        host_op_e              op;
        int                    waited;
        int                    refs_before;
        seed     = 87850;
        clk      = 1'b0;
        rst      = 1'b1;
        req      = 1'b0;
        req_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // First write is already waiting while the power-up sequence runs
        addr = {2'd2, 13'h1abc, 10'h2f5};
        raise_request(op_write, addr, 16'hc35a);
        waited = 0;
        while (!init_seen) begin
            @(posedge clk);
            waited++;
            if (waited > INIT_TIMEOUT) begin
                abort_run("initialization did not finish in time");
            end
        end
        finish_request(op_write, addr, 16'hc35a);
        host_access(op_read, addr, '0);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = random_addr();
            op   = (($random(seed) & 1) != 0) ? op_write : op_read;
            data = DATA_WIDTH'($random(seed));
            host_access(op, addr, data);
        end
        // Idle stretch, refresh keeps going without traffic
        refs_before = ref_count;
        repeat (3 * REFRESH_INTERVAL) @(posedge clk);
        if (ref_count - refs_before < 2) begin
            abort_run("too few auto_refresh commands during the idle stretch");
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sdram_model.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_model
    import sdram_pkg::*;
#(
    parameter int CAS_LATENCY = 2
) (
    input  logic                  clk,
    input  sdram_pins_t           pins,
    input  logic [DATA_WIDTH-1:0] dq_out,
    input  logic                  dq_oe,
    output logic [DATA_WIDTH-1:0] dq_in
);

    logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
    logic [ROW_WIDTH-1:0]  open_row [0:(1<<BANK_WIDTH)-1];
    logic [DATA_WIDTH-1:0] rd_pipe [0:CAS_LATENCY-1];
    logic [ADDR_WIDTH-1:0] loc;

    // Column against the row that is open in the addressed bank
    assign loc   = {pins.ba, open_row[pins.ba], pins.a[COL_WIDTH-1:0]};
    assign dq_in = rd_pipe[CAS_LATENCY-1];

    initial begin
        for (int i = 0; i < CAS_LATENCY; i++) begin
            rd_pipe[i] = '0;
        end
    end

    // DQM is not modeled, unwritten words read as zero
    always @(posedge clk) begin
        for (int i = CAS_LATENCY - 1; i > 0; i--) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        rd_pipe[0] <= '0;
        if (!pins.cs_n) begin
            case ({pins.ras_n, pins.cas_n, pins.we_n})
                3'b011: open_row[pins.ba] <= pins.a;
                3'b101: rd_pipe[0] <= mem.exists(loc) ? mem[loc] : '0;
                3'b100: begin
                    if (dq_oe) begin
                        mem[loc] = dq_out;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sdram_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_ctrl_top
    import sdram_pkg::*;
#(
    parameter int CAS_LATENCY      = 2,
    parameter int REFRESH_INTERVAL = 780,
    parameter int INIT_DELAY       = 10000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  host_req_t             req_data,
    input  logic [DATA_WIDTH-1:0] dq_in,
    output logic                  ack,
    output logic [DATA_WIDTH-1:0] rdata,
    output sdram_pins_t           pins,
    output logic [DATA_WIDTH-1:0] dq_out,
    output logic                  dq_oe
);

    logic                  pending;
    host_req_t             cur_req;
    logic                  done;
    logic [DATA_WIDTH-1:0] seq_rdata;
    logic                  refresh_due;
    logic                  refresh_issued;
    logic                  init_done_pulse;
    sdram_cmd_e            cmd;
    logic [BANK_WIDTH-1:0] ba;
    logic [ROW_WIDTH-1:0]  a;
    logic [DATA_WIDTH-1:0] wdata;

    host_port u_host_port (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .done     (done),
        .rdata_in (seq_rdata),
        .ack      (ack),
        .rdata    (rdata),
        .pending  (pending),
        .cur_req  (cur_req)
    );

    refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) u_refresh_timer (
        .clk             (clk),
        .rst             (rst),
        .init_done_pulse (init_done_pulse),
        .refresh_issued  (refresh_issued),
        .refresh_due     (refresh_due)
    );

    sdram_sequencer #(
        .CAS_LATENCY (CAS_LATENCY),
        .INIT_DELAY  (INIT_DELAY)
    ) u_sequencer (
        .clk             (clk),
        .rst             (rst),
        .pending         (pending),
        .cur_req         (cur_req),
        .refresh_due     (refresh_due),
        .dq_in           (dq_in),
        .done            (done),
        .rdata           (seq_rdata),
        .refresh_issued  (refresh_issued),
        .init_done_pulse (init_done_pulse),
        .cmd             (cmd),
        .ba              (ba),
        .a               (a),
        .wdata           (wdata)
    );

    sdram_cmd_encoder u_cmd_encoder (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .ba     (ba),
        .a      (a),
        .wdata  (wdata),
        .pins   (pins),
        .dq_out (dq_out),
        .dq_oe  (dq_oe)
    );

endmodule

`default_nettype wire

//--- hw/sdram_cmd_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_encoder
    import sdram_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_cmd_e            cmd,
    input  logic [BANK_WIDTH-1:0] ba,
    input  logic [ROW_WIDTH-1:0]  a,
    input  logic [DATA_WIDTH-1:0] wdata,
    output sdram_pins_t           pins,
    output logic [DATA_WIDTH-1:0] dq_out,
    output logic                  dq_oe
);

    localparam sdram_pins_t PINS_NOP = '{
        cke:   1'b1,
        cs_n:  1'b0,
        ras_n: 1'b1,
        cas_n: 1'b1,
        we_n:  1'b1,
        ba:    '0,
        a:     '0,
        dqm:   2'b11
    };

    sdram_pins_t pins_next;

    always_comb begin
        pins_next    = PINS_NOP;
        pins_next.ba = ba;
        pins_next.a  = a;
        // ras_n, cas_n, we_n
        case (cmd)
            cmd_active:        {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b011;
            cmd_read:          {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b101;
            cmd_write:         {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b100;
            cmd_precharge_all: {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b010;
            cmd_auto_refresh:  {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b001;
            cmd_load_mode:     {pins_next.ras_n, pins_next.cas_n, pins_next.we_n} = 3'b000;
            default: ;
        endcase
        if (cmd == cmd_read || cmd == cmd_write) begin
            pins_next.dqm = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pins  <= PINS_NOP;
            dq_oe <= 1'b0;
        end else begin
            pins  <= pins_next;
            dq_oe <= (cmd == cmd_write);
        end
    end

    always_ff @(posedge clk) begin
        dq_out <= wdata;
    end

    // Bus is driven only alongside a registered WRITE, never two cycles running
    assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> !pins.cs_n && pins.ras_n && !pins.cas_n && !pins.we_n);

    assert property (@(posedge clk) disable iff (rst) dq_oe |=> !dq_oe);

endmodule

`default_nettype wire

//--- hw/sdram_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module sdram_sequencer
    import sdram_pkg::*;
#(
    parameter int CAS_LATENCY = 2,
    parameter int INIT_DELAY  = 10000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pending,
    input  host_req_t             cur_req,
    input  logic                  refresh_due,
    input  logic [DATA_WIDTH-1:0] dq_in,
    output logic                  done,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  refresh_issued,
    output logic                  init_done_pulse,
    output sdram_cmd_e            cmd,
    output logic [BANK_WIDTH-1:0] ba,
    output logic [ROW_WIDTH-1:0]  a,
    output logic [DATA_WIDTH-1:0] wdata
);

    localparam int CNT_W  = $clog2(INIT_DELAY + 8);
    localparam int AP_BIT = 10;

    // Burst length 1, sequential, single write burst
    localparam logic [ROW_WIDTH-1:0] MODE_WORD =
        {3'b000, 1'b1, 2'b00, 3'(CAS_LATENCY), 1'b0, 3'b000};

    seq_state_e              state;
    seq_state_e              state_next;
    logic [CNT_W-1:0]        wait_cnt;
    logic [CNT_W-1:0]        state_len;
    logic                    first;
    logic                    last;
    logic                    ref_second;
    host_req_t               req_q;
    logic [DATA_WIDTH-1:0]   rdata_q;
    logic [BANK_WIDTH-1:0]   req_bank;
    logic [ROW_WIDTH-1:0]    req_row;
    logic [COL_WIDTH-1:0]    req_col;

    assign req_bank = req_q.addr[ADDR_WIDTH-1 -: BANK_WIDTH];
    assign req_row  = req_q.addr[COL_WIDTH +: ROW_WIDTH];
    assign req_col  = req_q.addr[COL_WIDTH-1:0];

    // Cycles spent in each state, command goes out on the first
    always_comb begin
        case (state)
            init_wait: state_len = CNT_W'(INIT_DELAY);
            init_pre:  state_len = CNT_W'(2);
            init_ref:  state_len = CNT_W'(8);
            init_mode: state_len = CNT_W'(3);
            cas_wait:  state_len = CNT_W'(CAS_LATENCY + 1);
            recover:   state_len = (req_q.op == op_write) ? CNT_W'(4) : CNT_W'(1);
            ref_pre:   state_len = CNT_W'(2);
            ref_wait:  state_len = CNT_W'(7);
            default:   state_len = CNT_W'(1);
        endcase
    end

    assign first = (wait_cnt == '0);
    assign last  = (wait_cnt == state_len - 1'b1);

    always_comb begin
        state_next = state;
        if (last) begin
            case (state)
                init_wait: state_next = init_pre;
                init_pre:  state_next = init_ref;
                init_ref:  state_next = ref_second ? init_mode : init_ref;
                init_mode: state_next = idle;
                idle: begin
                    // Refresh wins over a waiting host request
                    if (refresh_due) begin
                        state_next = ref_pre;
                    end else if (pending) begin
                        state_next = act;
                    end
                end
                act:       state_next = rcd_wait;
                rcd_wait:  state_next = rw_cmd;
                rw_cmd:    state_next = (req_q.op == op_write) ? recover : cas_wait;
                cas_wait:  state_next = recover;
                recover:   state_next = idle;
                ref_pre:   state_next = ref_auto;
                ref_auto:  state_next = ref_wait;
                ref_wait:  state_next = idle;
                default:   state_next = init_wait;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= init_wait;
            wait_cnt   <= '0;
            ref_second <= 1'b0;
        end else begin
            state    <= state_next;
            wait_cnt <= last ? '0 : wait_cnt + 1'b1;
            if (state == init_ref && last) begin
                ref_second <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && state_next == act) begin
            req_q <= cur_req;
        end
        // Last wait cycle lines up with read data behind the encoder stage
        if (state == cas_wait && last) begin
            rdata_q <= dq_in;
        end
    end

    always_comb begin
        cmd = cmd_nop;
        ba  = '0;
        a   = '0;
        case (state)
            init_pre, ref_pre: begin
                if (first) begin
                    cmd       = cmd_precharge_all;
                    a[AP_BIT] = 1'b1;
                end
            end
            init_ref: begin
                if (first) begin
                    cmd = cmd_auto_refresh;
                end
            end
            init_mode: begin
                if (first) begin
                    cmd = cmd_load_mode;
                    a   = MODE_WORD;
                end
            end
            act: begin
                cmd = cmd_active;
                ba  = req_bank;
                a   = req_row;
            end
            rw_cmd: begin
                cmd                = (req_q.op == op_write) ? cmd_write : cmd_read;
                ba                 = req_bank;
                a[COL_WIDTH-1:0]   = req_col;
                // Auto-precharge closes the row
                a[AP_BIT]          = 1'b1;
            end
            ref_auto: cmd = cmd_auto_refresh;
            default: ;
        endcase
    end

    assign done            = (state == recover) && last;
    assign rdata           = rdata_q;
    assign refresh_issued  = (state == ref_auto);
    assign init_done_pulse = (state == init_mode) && last;
    assign wdata           = req_q.wdata;

    // Every write follows its ACTIVE by exactly one NOP
    assert property (@(posedge clk) disable iff (rst)
        (cmd == cmd_write) |-> ($past(cmd, 2) == cmd_active) && (state == rw_cmd)
            && (req_q.op == op_write));

endmodule

`default_nettype wire

//--- hw/refresh_timer.sv
`timescale 1ns/10ps
`default_nettype none

module refresh_timer #(
    parameter int REFRESH_INTERVAL = 780
) (
    input  logic clk,
    input  logic rst,
    input  logic init_done_pulse,
    input  logic refresh_issued,
    output logic refresh_due
);

    localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] count;
    logic             armed;

    always_ff @(posedge clk) begin
        if (rst) begin
            count       <= '0;
            armed       <= 1'b0;
            refresh_due <= 1'b0;
        end else if (refresh_issued || init_done_pulse) begin
            count       <= CNT_W'(REFRESH_INTERVAL - 1);
            armed       <= 1'b1;
            refresh_due <= 1'b0;
        end else if (armed && !refresh_due) begin
            if (count == '0) begin
                refresh_due <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Due flag is sticky until serviced
    assert property (@(posedge clk) disable iff (rst)
        (refresh_due && !refresh_issued) |=> refresh_due);

endmodule

`default_nettype wire

//--- hw/host_port.sv
`timescale 1ns/10ps
`default_nettype none

module host_port
    import sdram_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  host_req_t             req_data,
    input  logic                  done,
    input  logic [DATA_WIDTH-1:0] rdata_in,
    output logic                  ack,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  pending,
    output host_req_t             cur_req
);

    typedef enum logic [1:0] {
        wait_req,
        busy,
        acked
    } port_state_e;

    port_state_e state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wait_req;
        end else begin
            case (state)
                wait_req: begin
                    if (req) begin
                        state <= busy;
                    end
                end
                busy: begin
                    if (done) begin
                        state <= acked;
                    end
                end
                acked: begin
                    // Hold ack until the host lets go of req
                    if (!req) begin
                        state <= wait_req;
                    end
                end
                default: state <= wait_req;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == wait_req && req) begin
            cur_req <= req_data;
        end
        if (state == busy && done && cur_req.op == op_read) begin
            rdata <= rdata_in;
        end
    end

    assign pending = (state == busy);
    assign ack     = (state == acked);

    // Four-phase rule: ack only drops after req has dropped
    assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack);

endmodule

`default_nettype wire

//--- hw/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // Device geometry, 16-bit x 4 banks x 8192 rows x 1024 columns
    localparam int DATA_WIDTH = 16;
    localparam int BANK_WIDTH = 2;
    localparam int ROW_WIDTH  = 13;
    localparam int COL_WIDTH  = 10;
    localparam int ADDR_WIDTH = BANK_WIDTH + ROW_WIDTH + COL_WIDTH;

    // Commands the sequencer hands to the pin encoder
    typedef enum logic [2:0] {
        cmd_nop,
        cmd_active,
        cmd_read,
        cmd_write,
        cmd_precharge_all,
        cmd_auto_refresh,
        cmd_load_mode
    } sdram_cmd_e;

    typedef enum logic {
        op_read,
        op_write
    } host_op_e;

    // Address is bank in the top bits, then row, then column
    typedef struct packed {
        host_op_e                op;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
    } host_req_t;

    typedef struct packed {
        logic                    cke;
        logic                    cs_n;
        logic                    ras_n;
        logic                    cas_n;
        logic                    we_n;
        logic [BANK_WIDTH-1:0]   ba;
        logic [ROW_WIDTH-1:0]    a;
        logic [1:0]              dqm;
    } sdram_pins_t;

    typedef enum logic [3:0] {
        init_wait,
        init_pre,
        init_ref,
        init_mode,
        idle,
        act,
        rcd_wait,
        rw_cmd,
        cas_wait,
        recover,
        ref_pre,
        ref_auto,
        ref_wait
    } seq_state_e;

endpackage

`default_nettype wire
